//--- dv/clk_rst_trace.txt
# kind name dom(0 soc 1 per 2 cluster) addr data(hex) exp(hex)
# per/lk use data as count, sel uses data as select value, rst uses data as test mode
rd soc_st 0 0 0 2
rd per_st 1 0 0 2
rd cl_st 2 0 0 2
rd soc_div 0 1 0 3
rd per_div 1 1 0 5
rd cl_div 2 1 0 7
rd soc_lk 0 2 0 4
rd per_lk 1 2 0 4
rd cl_lk 2 2 0 4
rd soc_ctl 0 3 0 1
wr soc_div_w 0 1 00000109 0
wr soc_lk_w 0 2 00000306 0
rd soc_div_r 0 1 0 9
rd soc_lk_r 0 2 0 6
wr soc_st_w 0 0 ffffffff 0
rd soc_st_r 0 0 0 2
per soc_per 0 0 3 a
wr soc_div_w2 0 1 00000004 0
lk soc_lk0 0 0 0 0
lk soc_lk5 0 0 5 0
lk soc_lk6 0 0 1 1
wr per_div_w 1 1 00000002 0
per per_per 1 0 3 3
wr cl_div_w 2 1 0000000b 0
per cl_per 2 0 3 c
wr soc_off 0 3 00000000 0
lk soc_off_lk 0 0 0 0
per soc_quiet 0 0 28 0
rd soc_st_off 0 0 0 0
lk soc_off_lk2 0 0 0 0
sel ref_on 0 0 1 a
sel ref_off 0 0 0 0
rst soc_rst 0 0 0 2
rst cl_rst 2 0 0 2
rst soc_tm 0 0 1 0
rst cl_tm 2 0 1 0
rst soc_rst2 0 0 0 2

//--- dv/tb_soc_clk_rst_gen.sv
`timescale 1ns/1ps
`include "clk_rst_settings.svh"

module tb_soc_clk_rst_gen import fll_cfg_pkg::*, clk_rst_pkg::*; ();

    logic         clk;
    logic         reset_i;
    logic         test_mode_i;
    logic         sel_ref_i;
    domain_tick_t req;
    domain_tick_t wrn;
    fll_addr_e    add [3];
    fll_data_t    wdata [3];
    domain_tick_t ack;
    domain_tick_t lock;
    domain_tick_t en;
    fll_data_t    rdata [3];
    logic         rst_soc;
    logic         rst_cluster;

    string       kinds[$];
    string       names[$];
    int          doms[$];
    int          addrs[$];
    logic [31:0] datas[$];
    logic [31:0] exps[$];

    logic [31:0] lfsr;
    int          errors;
    int          cycles;
    int          limit;

    soc_clk_rst_gen DUT (
        .clk                  (clk),
        .reset_i              (reset_i),
        .test_mode_i          (test_mode_i),
        .sel_ref_i            (sel_ref_i),
        .soc_cfg_req_i        (req[SOC]),
        .soc_cfg_wrn_i        (wrn[SOC]),
        .soc_cfg_add_i        (add[SOC]),
        .soc_cfg_data_i       (wdata[SOC]),
        .soc_cfg_ack_o        (ack[SOC]),
        .soc_cfg_r_data_o     (rdata[SOC]),
        .soc_lock_o           (lock[SOC]),
        .clk_soc_en_o         (en[SOC]),
        .per_cfg_req_i        (req[PER]),
        .per_cfg_wrn_i        (wrn[PER]),
        .per_cfg_add_i        (add[PER]),
        .per_cfg_data_i       (wdata[PER]),
        .per_cfg_ack_o        (ack[PER]),
        .per_cfg_r_data_o     (rdata[PER]),
        .per_lock_o           (lock[PER]),
        .clk_per_en_o         (en[PER]),
        .cluster_cfg_req_i    (req[CLUSTER]),
        .cluster_cfg_wrn_i    (wrn[CLUSTER]),
        .cluster_cfg_add_i    (add[CLUSTER]),
        .cluster_cfg_data_i   (wdata[CLUSTER]),
        .cluster_cfg_ack_o    (ack[CLUSTER]),
        .cluster_cfg_r_data_o (rdata[CLUSTER]),
        .cluster_lock_o       (lock[CLUSTER]),
        .clk_cluster_en_o     (en[CLUSTER]),
        .rst_soc_o            (rst_soc),
        .rst_cluster_o        (rst_cluster)
    );

    always #50 clk = ~clk;

    // run limit is set once the trace is loaded
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles", cycles);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) return (s >> 1) ^ 32'h80200003;
        return s >> 1;
    endfunction

    function automatic logic domain_rst(input int d);
        return (domain_e'(d) == CLUSTER) ? rst_cluster : rst_soc;
    endfunction

    task automatic report_failure(input string what);
        errors++;
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_data(input string nm, input fll_data_t exp, input fll_data_t act);
        if (act !== exp)
            report_failure($sformatf("mismatch %s expected %h actual %h", nm, exp, act));
    endtask

    task automatic check_bit(input string nm, input logic exp, input logic act);
        if (act !== exp)
            report_failure($sformatf("mismatch %s expected %b actual %b", nm, exp, act));
    endtask

    task automatic check_div(input string nm, input fll_div_t exp, input fll_div_t act);
        if (act !== exp)
            report_failure($sformatf("mismatch %s expected %0d actual %0d", nm, exp, act));
    endtask

    // 0 to 3 idle cycles with one lfsr step per bit
    task automatic idle_gap();
        int n;
        n = 0;
        repeat (2) begin
            lfsr = lfsr_next(lfsr);
            n = (n << 1) | lfsr[0];
        end
        repeat (n) @(posedge clk);
    endtask

    task automatic access(input string nm, input int d, input logic rd, input int a,
                          input fll_data_t wd, output fll_data_t rdv, output logic lk);
        int n;
        idle_gap();
        @(posedge clk);
        req[d]   <= 1'b1;
        wrn[d]   <= rd;
        add[d]   <= fll_addr_e'(a);
        wdata[d] <= wd;
        @(negedge clk);
        lk = lock[d];  // level the status register captures
        @(posedge clk);  // req sampled here
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!ack[d] && n < 4);
        if (!ack[d])
            report_failure($sformatf("%s got no ack from the generator", nm));
        if (n != 1)
            report_failure($sformatf("%s ack came %0d cycles after req", nm, n));
        rdv = rdata[d];
        @(posedge clk);
        req[d] <= 1'b0;
    endtask

    task automatic wait_pulse(input string nm, input int d, output int n);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!en[d] && n < 600);
        if (!en[d])
            report_failure($sformatf("%s saw no clock enable pulse", nm));
    endtask

    task automatic measure_period(input string nm, input int d, input int cnt, input int exp);
        int n;
        if (exp == 0) begin
            repeat (cnt) begin
                @(negedge clk);
                check_bit(nm, 1'b0, en[d]);
            end
        end else begin
            wait_pulse(nm, d, n);
            repeat (cnt) begin
                wait_pulse(nm, d, n);
                check_div(nm, fll_div_t'(exp), fll_div_t'(n));
            end
        end
    endtask

    task automatic lock_expect(input string nm, input int d, input int cnt, input logic exp);
        int n;
        if (cnt == 0) @(negedge clk);
        repeat (cnt) wait_pulse(nm, d, n);
        check_bit(nm, exp, lock[d]);
    endtask

    task automatic select_ref(input string nm, input logic v, input int cnt);
        @(posedge clk);
        sel_ref_i <= v;
        @(negedge clk);  // still the old rate
        repeat (cnt) begin
            @(negedge clk);
            check_bit(nm, 1'b1, en[SOC]);
            check_bit(nm, 1'b1, en[PER]);
            check_bit(nm, 1'b1, en[CLUSTER]);
        end
    endtask

    task automatic reset_expect(input string nm, input int d, input logic tm, input int exp);
        int n;
        int c;
        @(posedge clk);
        reset_i     <= 1'b1;
        test_mode_i <= tm;
        repeat (16) @(posedge clk);
        @(negedge clk);
        check_bit(nm, 1'b1, domain_rst(d));
        @(posedge clk);
        reset_i <= 1'b0;
        n = 0;
        c = 0;
        @(negedge clk);
        while (domain_rst(d) && c < 600) begin
            if (en[d]) n++;  // domain ticks seen before release
            c++;
            @(negedge clk);
        end
        if (domain_rst(d))
            report_failure($sformatf("%s reset was never released", nm));
        check_div(nm, fll_div_t'(exp), fll_div_t'(n));
    endtask

    task automatic load_trace();
        int    fd;
        int    r;
        int    dv[3];
        string kind;
        string nm;
        string line;
        int    d;
        int    a;
        logic [31:0] dat;
        logic [31:0] ex;
        dv[0] = `FLL_SOC_DIV;
        dv[1] = `FLL_PER_DIV;
        dv[2] = `FLL_CLUSTER_DIV;
        limit = 40 + 16;
        fd = $fopen("dv/clk_rst_trace.txt", "r");
        if (fd == 0) report_failure("cannot open the trace file");
        while (!$feof(fd)) begin
            r = $fscanf(fd, "%s", kind);
            if (r != 1) break;
            if (kind == "#") begin
                r = $fgets(line, fd);
                continue;
            end
            r = $fscanf(fd, " %s %d %d %h %h", nm, d, a, dat, ex);
            if (r != 5) report_failure($sformatf("bad trace record %s", kind));
            kinds.push_back(kind);
            names.push_back(nm);
            doms.push_back(d);
            addrs.push_back(a);
            datas.push_back(dat);
            exps.push_back(ex);
            if (kind == "wr" || kind == "rd") begin
                limit += 8;
                if (kind == "wr" && a == 1) dv[d] = dat[7:0];
            end else if (kind == "per") begin
                limit += (ex != 0) ? ex * (dat + 2) : dat + 2;
            end else if (kind == "lk") begin
                limit += (dv[d] + 1) * (dat + 2);
            end else if (kind == "sel") begin
                limit += ex + 4;
            end else begin
                dv[0] = `FLL_SOC_DIV;
                dv[1] = `FLL_PER_DIV;
                dv[2] = `FLL_CLUSTER_DIV;
                limit += 24 + (dv[d] + 1) * (ex + 2);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        fll_data_t rv;
        logic      lk;
        clk         = 1'b0;
        reset_i     = 1'b1;
        test_mode_i = 1'b0;
        sel_ref_i   = 1'b0;
        req         = '0;
        wrn         = '0;
        for (int i = 0; i < 3; i++) begin
            add[i]   = FLL_STATUS;
            wdata[i] = '0;
        end
        lfsr   = 32'h72408493;
        errors = 0;
        cycles = 0;
        limit  = 0;
        repeat (16) @(posedge clk);
        reset_i <= 1'b0;
        load_trace();
        for (int i = 0; i < kinds.size(); i++) begin
            case (kinds[i])
                "wr":  access(names[i], doms[i], 1'b0, addrs[i], datas[i], rv, lk);
                "rd": begin
                    access(names[i], doms[i], 1'b1, addrs[i], '0, rv, lk);
                    check_data(names[i], exps[i], rv);
                    if (addrs[i] == FLL_STATUS)
                        check_bit({names[i], "_lock"}, exps[i][FLL_ST_LOCK_BIT], lk);
                end
                "per": measure_period(names[i], doms[i], datas[i], exps[i]);
                "lk":  lock_expect(names[i], doms[i], datas[i], exps[i][0]);
                "sel": select_ref(names[i], datas[i][0], exps[i]);
                "rst": reset_expect(names[i], doms[i], datas[i][0], exps[i]);
                default: report_failure($sformatf("unknown trace record %s", kinds[i]));
            endcase
        end
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- rtl/clk_rst_pkg.sv
package clk_rst_pkg;

    localparam int unsigned NUM_DOMAINS = 3;

    // clock domains served by the generator
    typedef enum logic [1:0] {
        SOC     = 2'd0,
        PER     = 2'd1,
        CLUSTER = 2'd2
    } domain_e;

    // one bit per domain, indexed by domain_e
    typedef logic [NUM_DOMAINS-1:0] domain_tick_t;

endpackage

//--- rtl/clk_rst_settings.svh
`ifndef CLK_RST_SETTINGS_SVH
`define CLK_RST_SETTINGS_SVH

// config port word
`define FLL_DATA_W 32

// divider field, tick period is div+1 ref cycles
`define FLL_DIV_W 8

// per-domain divider after reset
`define FLL_SOC_DIV     3
`define FLL_PER_DIV     5
`define FLL_CLUSTER_DIV 7

// ticks needed before lock goes high
`define FLL_LOCK_DEF 4

// reset release depth in domain ticks
`define RST_SYNC_STAGES 2

`endif

//--- rtl/fll_cfg_pkg.sv
`include "clk_rst_settings.svh"

package fll_cfg_pkg;

    // four-register map of the generator config port
    typedef enum logic [1:0] {
        FLL_STATUS = 2'd0,  // read-only
        FLL_DIV    = 2'd1,
        FLL_LOCK   = 2'd2,
        FLL_CTRL   = 2'd3
    } fll_addr_e;

    typedef logic [`FLL_DATA_W-1:0] fll_data_t;
    typedef logic [`FLL_DIV_W-1:0]  fll_div_t;

    // lock threshold and tick count
    typedef logic [7:0] fll_lock_t;

    // field positions
    localparam int unsigned FLL_ST_LOCK_BIT = 0;
    localparam int unsigned FLL_ST_EN_BIT   = 1;
    localparam int unsigned FLL_CTRL_EN_BIT = 0;

endpackage

//--- rtl/fll_core.sv
`timescale 1ns/1ps
`include "clk_rst_settings.svh"

module fll_core import fll_cfg_pkg::*; #(
    parameter int unsigned DEF_DIV = 3
) (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      cfg_req_i,
    input  logic      cfg_wrn_i,     // high for read
    input  fll_addr_e cfg_add_i,
    input  fll_data_t cfg_data_i,
    output logic      cfg_ack_o,
    output fll_data_t cfg_r_data_o,
    output logic      lock_o,
    output logic      tick_o
);

    logic      ack_q;
    fll_data_t r_data_q;
    fll_data_t rd_data;

    fll_div_t  div_q;
    fll_lock_t thr_q;
    logic      en_q;

    fll_div_t  cnt_q;
    logic      tick_q;
    fll_lock_t tcnt_q;
    fll_lock_t tcnt_inc;
    logic      lock_q;

    logic      cfg_acc;
    logic      cfg_wr;
    logic      restart;
    logic      wrap;

    assign cfg_acc  = cfg_req_i && !ack_q;  // first cycle req is seen
    assign cfg_wr   = cfg_acc && !cfg_wrn_i;
    assign restart  = cfg_wr && (cfg_add_i == FLL_DIV || cfg_add_i == FLL_CTRL);
    assign wrap     = en_q && (cnt_q == div_q);
    assign tcnt_inc = (tcnt_q == '1) ? tcnt_q : tcnt_q + 1'b1;  // saturate

    // register readback
    always_comb begin
        rd_data = '0;
        case (cfg_add_i)
            FLL_STATUS: begin
                rd_data[FLL_ST_LOCK_BIT] = lock_q;
                rd_data[FLL_ST_EN_BIT]   = en_q;
            end
            FLL_DIV:  rd_data = fll_data_t'(div_q);
            FLL_LOCK: rd_data = fll_data_t'(thr_q);
            FLL_CTRL: rd_data[FLL_CTRL_EN_BIT] = en_q;
            default:  rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= cfg_acc;
        end
    end

    // captured with the access, valid in the ack cycle
    always_ff @(posedge clk) begin
        if (cfg_acc) begin
            r_data_q <= rd_data;
        end
    end

    // writes land on the same edge that raises ack
    always_ff @(posedge clk) begin
        if (reset_i) begin
            div_q <= fll_div_t'(DEF_DIV);
            thr_q <= fll_lock_t'(`FLL_LOCK_DEF);
            en_q  <= 1'b1;
        end else if (cfg_wr) begin
            case (cfg_add_i)
                FLL_DIV:  div_q <= fll_div_t'(cfg_data_i);
                FLL_LOCK: thr_q <= fll_lock_t'(cfg_data_i);
                FLL_CTRL: en_q  <= cfg_data_i[FLL_CTRL_EN_BIT];
                default:  ;  // status ignores writes
            endcase
        end
    end

    // wrap counter, one tick per div+1 cycles
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cnt_q  <= '0;
            tick_q <= 1'b0;
        end else if (restart || !en_q) begin
            cnt_q  <= '0;
            tick_q <= 1'b0;
        end else begin
            tick_q <= wrap;
            cnt_q  <= wrap ? '0 : cnt_q + 1'b1;
        end
    end

    // lock once enough ticks since the last restart
    always_ff @(posedge clk) begin
        if (reset_i) begin
            tcnt_q <= '0;
            lock_q <= 1'b0;
        end else if (restart || !en_q) begin
            tcnt_q <= '0;
            lock_q <= 1'b0;
        end else if (wrap) begin
            tcnt_q <= tcnt_inc;
            lock_q <= lock_q || (tcnt_inc >= thr_q);  // rises with that tick
        end
    end

    assign cfg_ack_o    = ack_q;
    assign cfg_r_data_o = r_data_q;
    assign tick_o       = tick_q;
    assign lock_o       = lock_q;

    // master must leave a gap after every ack
    a_req_gap: assert property (@(posedge clk) disable iff (reset_i)
        cfg_ack_o |=> !cfg_req_i)
        else $error("fll_core: req raised in the cycle after ack");

    a_req_stable: assert property (@(posedge clk) disable iff (reset_i)
        cfg_req_i && !cfg_ack_o |=> $stable(cfg_wrn_i) && $stable(cfg_add_i)
            && $stable(cfg_data_i))
        else $error("fll_core: request changed before ack");

    // disabled generator stays silent
    a_no_tick_off: assert property (@(posedge clk) disable iff (reset_i)
        !en_q |-> !tick_o)
        else $error("fll_core: tick while disabled");

endmodule

//--- rtl/rst_sync.sv
`timescale 1ns/1ps

module rst_sync #(
    parameter int unsigned STAGES = 2
) (
    input  logic clk,
    input  logic reset_i,
    input  logic tick_i,       // domain clock enable
    input  logic test_mode_i,
    output logic rst_o
);

    logic [STAGES-1:0] sync_q;

    // all ones in reset, one zero shifted in per domain tick
    always_ff @(posedge clk) begin
        if (reset_i) begin
            sync_q <= '1;
        end else if (tick_i) begin
            sync_q <= sync_q << 1;
        end
    end

    // test mode skips the release delay
    assign rst_o = test_mode_i ? reset_i : sync_q[STAGES-1];

    // held reset must reach the output, in either mode
    a_rst_held: assert property (@(posedge clk)
        reset_i [*2] |-> rst_o)
        else $error("rst_sync: output low while reset held");

endmodule

//--- rtl/soc_clk_rst_gen.sv
`timescale 1ns/1ps
`include "clk_rst_settings.svh"

module soc_clk_rst_gen import fll_cfg_pkg::*, clk_rst_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      test_mode_i,
    input  logic      sel_ref_i,     // force reference rate

    input  logic      soc_cfg_req_i,
    input  logic      soc_cfg_wrn_i,
    input  fll_addr_e soc_cfg_add_i,
    input  fll_data_t soc_cfg_data_i,
    output logic      soc_cfg_ack_o,
    output fll_data_t soc_cfg_r_data_o,
    output logic      soc_lock_o,
    output logic      clk_soc_en_o,

    input  logic      per_cfg_req_i,
    input  logic      per_cfg_wrn_i,
    input  fll_addr_e per_cfg_add_i,
    input  fll_data_t per_cfg_data_i,
    output logic      per_cfg_ack_o,
    output fll_data_t per_cfg_r_data_o,
    output logic      per_lock_o,
    output logic      clk_per_en_o,

    input  logic      cluster_cfg_req_i,
    input  logic      cluster_cfg_wrn_i,
    input  fll_addr_e cluster_cfg_add_i,
    input  fll_data_t cluster_cfg_data_i,
    output logic      cluster_cfg_ack_o,
    output fll_data_t cluster_cfg_r_data_o,
    output logic      cluster_lock_o,
    output logic      clk_cluster_en_o,

    output logic      rst_soc_o,
    output logic      rst_cluster_o
);

    domain_tick_t fll_tick;   // raw generator ticks
    domain_tick_t dom_en_q;   // selected rate per domain

    fll_core #(.DEF_DIV(`FLL_SOC_DIV)) i_fll_soc (
        .clk          (clk),
        .reset_i      (reset_i),
        .cfg_req_i    (soc_cfg_req_i),
        .cfg_wrn_i    (soc_cfg_wrn_i),
        .cfg_add_i    (soc_cfg_add_i),
        .cfg_data_i   (soc_cfg_data_i),
        .cfg_ack_o    (soc_cfg_ack_o),
        .cfg_r_data_o (soc_cfg_r_data_o),
        .lock_o       (soc_lock_o),
        .tick_o       (fll_tick[SOC])
    );

    fll_core #(.DEF_DIV(`FLL_PER_DIV)) i_fll_per (
        .clk          (clk),
        .reset_i      (reset_i),
        .cfg_req_i    (per_cfg_req_i),
        .cfg_wrn_i    (per_cfg_wrn_i),
        .cfg_add_i    (per_cfg_add_i),
        .cfg_data_i   (per_cfg_data_i),
        .cfg_ack_o    (per_cfg_ack_o),
        .cfg_r_data_o (per_cfg_r_data_o),
        .lock_o       (per_lock_o),
        .tick_o       (fll_tick[PER])
    );

    fll_core #(.DEF_DIV(`FLL_CLUSTER_DIV)) i_fll_cluster (
        .clk          (clk),
        .reset_i      (reset_i),
        .cfg_req_i    (cluster_cfg_req_i),
        .cfg_wrn_i    (cluster_cfg_wrn_i),
        .cfg_add_i    (cluster_cfg_add_i),
        .cfg_data_i   (cluster_cfg_data_i),
        .cfg_ack_o    (cluster_cfg_ack_o),
        .cfg_r_data_o (cluster_cfg_r_data_o),
        .lock_o       (cluster_lock_o),
        .tick_o       (fll_tick[CLUSTER])
    );

    // reference rate or generator tick per domain
    always_ff @(posedge clk) begin
        if (reset_i) begin
            dom_en_q <= '0;
        end else begin
            dom_en_q <= sel_ref_i ? '1 : fll_tick;
        end
    end

    assign clk_soc_en_o     = dom_en_q[SOC];
    assign clk_per_en_o     = dom_en_q[PER];
    assign clk_cluster_en_o = dom_en_q[CLUSTER];

    // per has no local reset release
    rst_sync #(.STAGES(`RST_SYNC_STAGES)) i_soc_rst_sync (
        .clk         (clk),
        .reset_i     (reset_i),
        .tick_i      (dom_en_q[SOC]),
        .test_mode_i (test_mode_i),
        .rst_o       (rst_soc_o)
    );

    rst_sync #(.STAGES(`RST_SYNC_STAGES)) i_cluster_rst_sync (
        .clk         (clk),
        .reset_i     (reset_i),
        .tick_i      (dom_en_q[CLUSTER]),
        .test_mode_i (test_mode_i),
        .rst_o       (rst_cluster_o)
    );

endmodule

//--- src.f
+incdir+rtl
rtl/fll_cfg_pkg.sv
rtl/clk_rst_pkg.sv
rtl/fll_core.sv
rtl/rst_sync.sv
rtl/soc_clk_rst_gen.sv
dv/tb_soc_clk_rst_gen.sv
